// ==== verilog/vga_pkg.sv ====
// VGA timing package with the pixel counter width, the colour word width and the default geometry.

`default_nettype none

package vga_pkg;

    localparam int COORD_W = 11; // pixel counters and mouse coordinates share this width.
    localparam int RGB_W   = 12; // four bits each of red, green and blue.

    // The defaults give the 1024x768 mode at 60 Hz.
    localparam logic [COORD_W-1:0] DEF_H_ACTIVE = 11'd1024; // visible pixels per line.
    localparam logic [COORD_W-1:0] DEF_H_FRONT  = 11'd24;   // pixels between active area and sync.
    localparam logic [COORD_W-1:0] DEF_H_SYNC   = 11'd136;  // width of the horizontal sync pulse.
    localparam logic [COORD_W-1:0] DEF_H_BACK   = 11'd160;  // pixels between sync and next line.

    localparam logic [COORD_W-1:0] DEF_V_ACTIVE = 11'd768; // visible lines per frame.
    localparam logic [COORD_W-1:0] DEF_V_FRONT  = 11'd3;   // lines between active area and sync.
    localparam logic [COORD_W-1:0] DEF_V_SYNC   = 11'd6;   // width of the vertical sync pulse.
    localparam logic [COORD_W-1:0] DEF_V_BACK   = 11'd29;  // lines between sync and next frame.

    // A total line of 1344 pixels and a total frame of 806 lines both fit in COORD_W bits.

endpackage

`default_nettype wire

// ==== verilog/ui_pkg.sv ====
// User interface package with the screen states, the screen colours and the on-screen shapes.

`default_nettype none

package ui_pkg;

    import vga_pkg::*;

    typedef enum logic [1:0] {
        MENU  = 2'b00,
        PLAY  = 2'b01,
        PAUSE = 2'b10
    } screen_state_e;

    // Colours are packed as red, green, blue from the top nibble down.
    localparam logic [RGB_W-1:0] MENU_RGB   = 12'h226; // dark blue menu background.
    localparam logic [RGB_W-1:0] PLAY_RGB   = 12'h040; // dark green playfield.
    localparam logic [RGB_W-1:0] PAUSE_RGB  = 12'h555; // grey pause screen.
    localparam logic [RGB_W-1:0] BUTTON_RGB = 12'hfa0; // orange start button.
    localparam logic [RGB_W-1:0] CURSOR_RGB = 12'hfff; // white cursor square.

    // The START button is clickable and painted over the same rectangle.
    localparam logic [COORD_W-1:0] BTN_X = 11'd16; // left edge of the button.
    localparam logic [COORD_W-1:0] BTN_Y = 11'd16; // top edge of the button.
    localparam logic [COORD_W-1:0] BTN_W = 11'd24; // button width in pixels.
    localparam logic [COORD_W-1:0] BTN_H = 11'd12; // button height in pixels.

    localparam logic [COORD_W-1:0] CURSOR_SIZE = 11'd4; // side of the square cursor.

endpackage

`default_nettype wire

// ==== verilog/vga_if.sv ====
// VGA stream interface carrying pixel counters, sync, blanking and colour between pipeline stages.

`default_nettype none

interface vga_if;

    import vga_pkg::*;

    logic [COORD_W-1:0] hcount; // current pixel within the line.
    logic [COORD_W-1:0] vcount; // current line within the frame.
    logic               hsync;
    logic               hblnk;
    logic               vsync;
    logic               vblnk;
    logic [RGB_W-1:0]   rgb;

    modport out (
        output hcount,
        output vcount,
        output hsync,
        output hblnk,
        output vsync,
        output vblnk,
        output rgb
    );

    modport in (
        input hcount,
        input vcount,
        input hsync,
        input hblnk,
        input vsync,
        input vblnk,
        input rgb
    );

endinterface

`default_nettype wire

// ==== verilog/vga_timing.sv ====
// VGA timing generator with free-running counters and registered sync and blanking.

`default_nettype none

module vga_timing #(
    parameter logic [vga_pkg::COORD_W-1:0] H_ACTIVE = vga_pkg::DEF_H_ACTIVE,
    parameter logic [vga_pkg::COORD_W-1:0] H_FRONT  = vga_pkg::DEF_H_FRONT,
    parameter logic [vga_pkg::COORD_W-1:0] H_SYNC   = vga_pkg::DEF_H_SYNC,
    parameter logic [vga_pkg::COORD_W-1:0] H_BACK   = vga_pkg::DEF_H_BACK,
    parameter logic [vga_pkg::COORD_W-1:0] V_ACTIVE = vga_pkg::DEF_V_ACTIVE,
    parameter logic [vga_pkg::COORD_W-1:0] V_FRONT  = vga_pkg::DEF_V_FRONT,
    parameter logic [vga_pkg::COORD_W-1:0] V_SYNC   = vga_pkg::DEF_V_SYNC,
    parameter logic [vga_pkg::COORD_W-1:0] V_BACK   = vga_pkg::DEF_V_BACK
) (
    input  logic clk,
    input  logic rst_n,
    vga_if.out   tim_out
);

    import vga_pkg::*;

    localparam logic [COORD_W-1:0] H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam logic [COORD_W-1:0] H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam logic [COORD_W-1:0] H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam logic [COORD_W-1:0] V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam logic [COORD_W-1:0] V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam logic [COORD_W-1:0] V_SYNC_END   = V_SYNC_START + V_SYNC;

    logic [COORD_W-1:0] h_cnt;
    logic [COORD_W-1:0] v_cnt;
    logic [COORD_W-1:0] h_cnt_nxt;
    logic [COORD_W-1:0] v_cnt_nxt;

    always_comb begin
        h_cnt_nxt = h_cnt + 1'b1;
        v_cnt_nxt = v_cnt;
        if (h_cnt == H_TOTAL - 1'b1) begin
            h_cnt_nxt = '0; // end of line starts the next one.
            v_cnt_nxt = (v_cnt == V_TOTAL - 1'b1) ? '0 : v_cnt + 1'b1;
        end
    end

    // The counters run one step ahead so the first edge out of reset shows pixel (0,0).
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_cnt          <= '0;
            v_cnt          <= '0;
            tim_out.hcount <= '0;
            tim_out.vcount <= '0;
            tim_out.hsync  <= 1'b0;
            tim_out.vsync  <= 1'b0;
            tim_out.hblnk  <= 1'b0;
            tim_out.vblnk  <= 1'b0;
        end else begin
            h_cnt          <= h_cnt_nxt;
            v_cnt          <= v_cnt_nxt;
            tim_out.hcount <= h_cnt;
            tim_out.vcount <= v_cnt;
            tim_out.hsync  <= (h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END);
            tim_out.vsync  <= (v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END);
            tim_out.hblnk  <= (h_cnt >= H_ACTIVE); // blanked past the visible pixels.
            tim_out.vblnk  <= (v_cnt >= V_ACTIVE); // blanked past the visible lines.
        end
    end

    assign tim_out.rgb = '0; // the timing stage carries no colour.

endmodule

`default_nettype wire

// ==== verilog/screen_state_fsm.sv ====
// Screen state machine that turns mouse clicks into the MENU, PLAY and PAUSE screens.

`default_nettype none

module screen_state_fsm (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [vga_pkg::COORD_W-1:0]   xpos,
    input  logic [vga_pkg::COORD_W-1:0]   ypos,
    input  logic                          mouse_left,
    input  logic                          mouse_right,
    output ui_pkg::screen_state_e         state
);

    import ui_pkg::*;

    logic          left_d;      // last cycle's left button level.
    logic          right_d;     // last cycle's right button level.
    logic          left_rise;
    logic          right_rise;
    logic          on_button;
    screen_state_e state_nxt;

    assign left_rise  = mouse_left && !left_d;   // a held button counts only once.
    assign right_rise = mouse_right && !right_d;

    assign on_button = (xpos >= BTN_X) && (xpos < BTN_X + BTN_W) &&
                       (ypos >= BTN_Y) && (ypos < BTN_Y + BTN_H);

    always_comb begin
        state_nxt = state;
        case (state)
            MENU: begin
                if (left_rise && on_button) begin
                    state_nxt = PLAY; // only the START button leaves the menu.
                end
            end
            PLAY: begin
                if (right_rise) begin
                    state_nxt = PAUSE;
                end
            end
            PAUSE: begin
                if (left_rise) begin
                    state_nxt = PLAY; // left wins when both buttons rise together.
                end else if (right_rise) begin
                    state_nxt = MENU;
                end
            end
            default: begin
                state_nxt = MENU; // the unused encoding falls back to the menu.
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= MENU;
            left_d  <= 1'b0;
            right_d <= 1'b0;
        end else begin
            state   <= state_nxt;
            left_d  <= mouse_left;
            right_d <= mouse_right;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/draw_background.sv ====
// Background painter that fills each screen in its colour and draws the START button on the menu.

`default_nettype none

module draw_background #(
    parameter logic [vga_pkg::COORD_W-1:0] H_ACTIVE = vga_pkg::DEF_H_ACTIVE,
    parameter logic [vga_pkg::COORD_W-1:0] V_ACTIVE = vga_pkg::DEF_V_ACTIVE
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  ui_pkg::screen_state_e state,
    vga_if.in                     bg_in,
    vga_if.out                    bg_out
);

    import vga_pkg::*;
    import ui_pkg::*;

    screen_state_e    state_frame; // screen shown during the current frame.
    screen_state_e    state_draw;
    logic             frame_start;
    logic             active;
    logic             in_button;
    logic [RGB_W-1:0] rgb_nxt;

    assign frame_start = (bg_in.hcount == '0) && (bg_in.vcount == '0);

    // The new state already applies to the first pixel of the frame.
    assign state_draw = frame_start ? state : state_frame;

    assign active = (bg_in.hcount < H_ACTIVE) && (bg_in.vcount < V_ACTIVE);

    assign in_button = (bg_in.hcount >= BTN_X) && (bg_in.hcount < BTN_X + BTN_W) &&
                       (bg_in.vcount >= BTN_Y) && (bg_in.vcount < BTN_Y + BTN_H);

    always_comb begin
        if (!active) begin
            rgb_nxt = '0; // the monitor expects black while blanked.
        end else if (state_draw == MENU && in_button) begin
            rgb_nxt = BUTTON_RGB;
        end else begin
            case (state_draw)
                PLAY:    rgb_nxt = PLAY_RGB;
                PAUSE:   rgb_nxt = PAUSE_RGB;
                default: rgb_nxt = MENU_RGB;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_frame   <= MENU;
            bg_out.hcount <= '0;
            bg_out.vcount <= '0;
            bg_out.hsync  <= 1'b0;
            bg_out.vsync  <= 1'b0;
            bg_out.hblnk  <= 1'b0;
            bg_out.vblnk  <= 1'b0;
            bg_out.rgb    <= '0;
        end else begin
            if (frame_start) begin
                state_frame <= state; // held for the rest of the frame.
            end
            bg_out.hcount <= bg_in.hcount;
            bg_out.vcount <= bg_in.vcount;
            bg_out.hsync  <= bg_in.hsync;
            bg_out.vsync  <= bg_in.vsync;
            bg_out.hblnk  <= bg_in.hblnk;
            bg_out.vblnk  <= bg_in.vblnk;
            bg_out.rgb    <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/draw_cursor.sv ====
// Cursor stage that overlays a square at the mouse position and registers the VGA pins.

`default_nettype none

module draw_cursor (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [vga_pkg::COORD_W-1:0] xpos,
    input  logic [vga_pkg::COORD_W-1:0] ypos,
    vga_if.in                           cur_in,
    output logic                        hs,
    output logic                        vs,
    output logic [vga_pkg::RGB_W-1:0]   rgb
);

    import vga_pkg::*;
    import ui_pkg::*;

    logic [COORD_W-1:0] x_frame; // cursor position held for the frame.
    logic [COORD_W-1:0] y_frame;
    logic [COORD_W-1:0] x_draw;
    logic [COORD_W-1:0] y_draw;
    logic               frame_start;
    logic               active;
    logic               in_cursor;
    logic [RGB_W-1:0]   rgb_nxt;

    assign frame_start = (cur_in.hcount == '0) && (cur_in.vcount == '0);

    assign x_draw = frame_start ? xpos : x_frame;
    assign y_draw = frame_start ? ypos : y_frame;

    assign active = !cur_in.hblnk && !cur_in.vblnk;

    // Offsets are compared instead of end points so a position near the counter limit cannot wrap.
    assign in_cursor = (cur_in.hcount >= x_draw) && (cur_in.hcount - x_draw < CURSOR_SIZE) &&
                       (cur_in.vcount >= y_draw) && (cur_in.vcount - y_draw < CURSOR_SIZE);

    always_comb begin
        if (active && in_cursor) begin
            rgb_nxt = CURSOR_RGB;
        end else begin
            rgb_nxt = cur_in.rgb; // the background shows through everywhere else.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            x_frame <= '0;
            y_frame <= '0;
            hs      <= 1'b0;
            vs      <= 1'b0;
            rgb     <= '0;
        end else begin
            if (frame_start) begin
                x_frame <= xpos;
                y_frame <= ypos;
            end
            hs  <= cur_in.hsync;
            vs  <= cur_in.vsync;
            rgb <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/top_vga.sv ====
// VGA screen top level connecting timing, screen selection, background and cursor to the pins.

`default_nettype none

module top_vga #(
    parameter logic [vga_pkg::COORD_W-1:0] H_ACTIVE = vga_pkg::DEF_H_ACTIVE,
    parameter logic [vga_pkg::COORD_W-1:0] H_FRONT  = vga_pkg::DEF_H_FRONT,
    parameter logic [vga_pkg::COORD_W-1:0] H_SYNC   = vga_pkg::DEF_H_SYNC,
    parameter logic [vga_pkg::COORD_W-1:0] H_BACK   = vga_pkg::DEF_H_BACK,
    parameter logic [vga_pkg::COORD_W-1:0] V_ACTIVE = vga_pkg::DEF_V_ACTIVE,
    parameter logic [vga_pkg::COORD_W-1:0] V_FRONT  = vga_pkg::DEF_V_FRONT,
    parameter logic [vga_pkg::COORD_W-1:0] V_SYNC   = vga_pkg::DEF_V_SYNC,
    parameter logic [vga_pkg::COORD_W-1:0] V_BACK   = vga_pkg::DEF_V_BACK
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [vga_pkg::COORD_W-1:0] xpos,
    input  logic [vga_pkg::COORD_W-1:0] ypos,
    input  logic                        mouse_left,
    input  logic                        mouse_right,
    output logic                        hs,
    output logic                        vs,
    output logic [3:0]                  r,
    output logic [3:0]                  g,
    output logic [3:0]                  b
);

    import vga_pkg::*;
    import ui_pkg::*;

    vga_if bg_in();  // timing generator to background painter.
    vga_if bg_out(); // background painter to cursor stage.

    screen_state_e    state;
    logic [RGB_W-1:0] rgb;

    assign {r, g, b} = rgb; // red sits in the top nibble.

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_vga_timing (
        .clk,
        .rst_n,
        .tim_out(bg_in)
    );

    screen_state_fsm u_screen_state_fsm (
        .clk,
        .rst_n,
        .xpos,
        .ypos,
        .mouse_left,
        .mouse_right,
        .state
    );

    draw_background #(
        .H_ACTIVE(H_ACTIVE),
        .V_ACTIVE(V_ACTIVE)
    ) u_draw_background (
        .clk,
        .rst_n,
        .state,
        .bg_in(bg_in),
        .bg_out(bg_out)
    );

    draw_cursor u_draw_cursor (
        .clk,
        .rst_n,
        .xpos,
        .ypos,
        .cur_in(bg_out),
        .hs,
        .vs,
        .rgb
    );

endmodule

`default_nettype wire

// ==== bench/top_vga_assertions.sv ====
// Bound checker for the VGA pins covering sync width, blanking during sync and reset values.

`default_nettype none

module top_vga_assertions #(
    parameter logic [vga_pkg::COORD_W-1:0] H_SYNC = vga_pkg::DEF_H_SYNC
) (
    input logic       clk,
    input logic       rst_n,
    input logic       hs,
    input logic       vs,
    input logic [3:0] r,
    input logic [3:0] g,
    input logic [3:0] b
);

    timeunit 1ns;
    timeprecision 1ps;

    import vga_pkg::*;

    logic [COORD_W-1:0] hs_len; // cycles the current line pulse has been high.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hs_len <= '0;
        end else if (hs) begin
            hs_len <= hs_len + 1'b1;
        end else begin
            hs_len <= '0;
        end
    end

    black_during_sync: assert property (@(posedge clk) disable iff (!rst_n)
        (hs || vs) |-> ({r, g, b} == 12'h000))
        else $error("colour is not black while a sync pulse is high");

    hs_not_too_long: assert property (@(posedge clk) disable iff (!rst_n)
        hs |-> (hs_len < H_SYNC))
        else $error("line sync pulse is longer than its nominal width");

    hs_not_too_short: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(hs) |-> (hs_len == H_SYNC))
        else $error("line sync pulse is shorter than its nominal width");

    pins_quiet_in_reset: assert property (@(posedge clk)
        !rst_n |=> (!hs && !vs && {r, g, b} == 12'h000))
        else $error("sync or colour pins are not zero during reset");

endmodule

bind top_vga top_vga_assertions #(
    .H_SYNC(H_SYNC)
) i_assertions (
    .clk(clk),
    .rst_n(rst_n),
    .hs(hs),
    .vs(vs),
    .r(r),
    .g(g),
    .b(b)
);

`default_nettype wire

// ==== bench/top_vga_tb.sv ====
// Testbench for the VGA screen top level with a screen model and a per-pixel reference check.

`default_nettype none

module top_vga_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import vga_pkg::*;
    import ui_pkg::*;

    localparam int H_ACT      = 64;
    localparam int V_ACT      = 48;
    localparam int H_TOT      = 80;     // 64 + 4 + 8 + 4 pixels per line.
    localparam int V_TOT      = 60;     // 48 + 2 + 3 + 7 lines per frame.
    localparam int HS_START   = 68;     // first pixel of the line pulse.
    localparam int VS_START   = 50;     // first line of the frame pulse.
    localparam int HS_WIDTH   = 8;
    localparam int VS_WIDTH   = 240;    // three whole lines.
    localparam int FRAME_LEN  = 4800;
    localparam int MAX_CYCLES = 100000; // about 18 frames are used, so this leaves some margin.

    logic               clk;
    logic               rst_n;
    logic [COORD_W-1:0] xpos;
    logic [COORD_W-1:0] ypos;
    logic               mouse_left;
    logic               mouse_right;
    logic               hs;
    logic               vs;
    logic [3:0]         r;
    logic [3:0]         g;
    logic [3:0]         b;

    screen_state_e    model_state;           // screen the model expects after the last click.
    screen_state_e    frame_state = MENU;    // screen latched for the frame on the pins.
    int               frame_mx = 0;
    int               frame_my = 0;
    int               px = 0;
    int               py = 0;
    logic             h_locked = 1'b0;
    logic             v_locked = 1'b0;
    logic             hs_prev = 1'b0;
    logic             vs_prev = 1'b0;
    logic             in_reset = 1'b1;
    int               hs_len = 0;
    int               vs_len = 0;
    int               hs_last = -1;
    int               vs_last = -1;
    int               hs_pulses = 0;
    int               vs_pulses = 0;
    int               cycle = 0;
    int               frame_count = 0;
    int               errors = 0;
    int               tests_run = 0;
    int               tests_failed = 0;
    logic [RGB_W-1:0] got;
    logic [RGB_W-1:0] want;

    top_vga #(
        .H_ACTIVE(11'd64), .H_FRONT(11'd4), .H_SYNC(11'd8), .H_BACK(11'd4),
        .V_ACTIVE(11'd48), .V_FRONT(11'd2), .V_SYNC(11'd3), .V_BACK(11'd7)
    ) i_dut (
        .clk(clk),
        .rst_n(rst_n),
        .xpos(xpos),
        .ypos(ypos),
        .mouse_left(mouse_left),
        .mouse_right(mouse_right),
        .hs(hs),
        .vs(vs),
        .r(r),
        .g(g),
        .b(b)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        in_reset <= !rst_n;
        cycle    <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic logic [RGB_W-1:0] expected_pixel(input screen_state_e st, input int x,
                                                         input int y, input int mx, input int my);
        if (x >= H_ACT || y >= V_ACT) begin
            return 12'h000; // blanked pixels are black.
        end
        if (x >= mx && x < mx + int'(CURSOR_SIZE) && y >= my && y < my + int'(CURSOR_SIZE)) begin
            return CURSOR_RGB;
        end
        if (st == MENU && x >= int'(BTN_X) && x < int'(BTN_X + BTN_W) &&
            y >= int'(BTN_Y) && y < int'(BTN_Y + BTN_H)) begin
            return BUTTON_RGB;
        end
        case (st)
            PLAY:    return PLAY_RGB;
            PAUSE:   return PAUSE_RGB;
            default: return MENU_RGB;
        endcase
    endfunction

    function automatic screen_state_e next_state(input screen_state_e st, input logic left,
                                                 input logic right, input int x, input int y);
        logic on_btn;
        on_btn = x >= int'(BTN_X) && x < int'(BTN_X + BTN_W) &&
                 y >= int'(BTN_Y) && y < int'(BTN_Y + BTN_H);
        case (st)
            MENU: begin
                if (left && on_btn) begin
                    return PLAY;
                end
            end
            PLAY: begin
                if (right) begin
                    return PAUSE;
                end
            end
            PAUSE: begin
                if (left) begin
                    return PLAY; // left wins over a simultaneous right click.
                end
                if (right) begin
                    return MENU;
                end
            end
            default: begin
                return MENU;
            end
        endcase
        return st;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        if (errors <= 50) begin
            $display("ERR %0d ns: %s", $time, msg);
        end
    endtask

    // Pixel position is rebuilt from the sync edges, then every locked pixel is compared.
    always @(negedge clk) begin
        if (in_reset) begin
            h_locked = 1'b0;
            v_locked = 1'b0;
            hs_prev  = 1'b0;
            vs_prev  = 1'b0;
            hs_len   = 0;
            vs_len   = 0;
            hs_last  = -1;
            vs_last  = -1;
        end else begin
            if (h_locked) begin
                if (px == H_TOT - 1) begin
                    px = 0;
                    if (v_locked) begin
                        py = (py == V_TOT - 1) ? 0 : py + 1;
                    end
                end else begin
                    px = px + 1;
                end
            end
            if (hs && !hs_prev) begin
                if (h_locked && px != HS_START) begin
                    report_error($sformatf("line pulse starts at pixel %0d, expected %0d",
                                           px, HS_START));
                end
                if (hs_last >= 0 && cycle - hs_last != H_TOT) begin
                    report_error($sformatf("line period %0d, expected %0d",
                                           cycle - hs_last, H_TOT));
                end
                hs_last  = cycle;
                px       = HS_START;
                h_locked = 1'b1;
                hs_pulses++;
            end
            if (!hs && hs_prev && hs_len != HS_WIDTH) begin
                report_error($sformatf("line pulse width %0d, expected %0d", hs_len, HS_WIDTH));
            end
            hs_len = hs ? hs_len + 1 : 0;
            if (vs && !vs_prev) begin
                if (v_locked && (py != VS_START || px != 0)) begin
                    report_error($sformatf("frame pulse starts at (%0d,%0d)", px, py));
                end
                if (vs_last >= 0 && cycle - vs_last != FRAME_LEN) begin
                    report_error($sformatf("frame period %0d, expected %0d",
                                           cycle - vs_last, FRAME_LEN));
                end
                vs_last  = cycle;
                py       = VS_START;
                v_locked = 1'b1;
                vs_pulses++;
            end
            if (!vs && vs_prev && vs_len != VS_WIDTH) begin
                report_error($sformatf("frame pulse width %0d, expected %0d", vs_len, VS_WIDTH));
            end
            vs_len  = vs ? vs_len + 1 : 0;
            hs_prev = hs;
            vs_prev = vs;
            if (h_locked && v_locked) begin
                if (px == 0 && py == 0) begin
                    frame_state = model_state; // the DUT takes its screen at frame start too.
                    frame_mx    = int'(xpos);
                    frame_my    = int'(ypos);
                    frame_count++;
                end
                want = expected_pixel(frame_state, px, py, frame_mx, frame_my);
                got  = {r, g, b};
                if (got !== want) begin
                    report_error($sformatf("pixel (%0d,%0d) is %03h, expected %03h",
                                           px, py, got, want));
                end
            end
        end
    end

    task automatic wait_frames(input int n);
        int target;
        target = frame_count + n;
        while (frame_count < target) begin
            @(negedge clk);
        end
    endtask

    task automatic skip_lines(input int n);
        repeat (n * H_TOT) @(negedge clk);
    endtask

    task automatic set_mouse(input int x, input int y);
        @(negedge clk);
        xpos = COORD_W'(x);
        ypos = COORD_W'(y);
    endtask

    task automatic press(input logic left, input logic right, input int hold);
        @(negedge clk);
        mouse_left  = left;
        mouse_right = right;
        model_state = next_state(model_state, left, right, int'(xpos), int'(ypos));
        repeat (hold) @(negedge clk);
        mouse_left  = 1'b0;
        mouse_right = 1'b0;
    endtask

    // Inputs change mid-frame, so the result shows on the whole following frame.
    task automatic click_step(input logic left, input logic right, input int hold,
                              input int x, input int y);
        skip_lines(20);
        set_mouse(x, y);
        press(left, right, hold);
        wait_frames(1);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %-16s ok", name);
        end else begin
            tests_failed++;
            $display("test %-16s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        int e0;
        int hs0;
        int vs0;
        int x;
        int y;
        void'($urandom(32'h403a_86ab));
        rst_n       = 1'b0;
        xpos        = COORD_W'(50);
        ypos        = COORD_W'(40);
        mouse_left  = 1'b0;
        mouse_right = 1'b0;
        model_state = MENU;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        e0 = errors;
        while (frame_count < 1) begin
            @(negedge clk);
        end
        hs0 = hs_pulses;
        vs0 = vs_pulses;
        wait_frames(1);
        if (hs_pulses - hs0 != V_TOT || vs_pulses - vs0 != 1) begin
            report_error($sformatf("saw %0d line and %0d frame pulses in one frame",
                                   hs_pulses - hs0, vs_pulses - vs0));
        end
        finish_test("sync_timing", e0);

        e0 = errors;
        wait_frames(1);
        finish_test("menu_screen", e0);

        e0 = errors;
        click_step(1'b1, 1'b0, 4, 5, 5);     // outside the button, stays on the menu.
        click_step(1'b1, 1'b0, 4, 20, 20);   // on the button, starts play.
        finish_test("start_click", e0);

        e0 = errors;
        click_step(1'b0, 1'b1, 2000, 20, 20); // a held right button pauses only once.
        click_step(1'b1, 1'b0, 4, 20, 20);
        click_step(1'b0, 1'b1, 4, 20, 20);
        click_step(1'b0, 1'b1, 4, 20, 20);
        finish_test("pause_return", e0);

        e0 = errors;
        for (int i = 0; i < 5; i++) begin
            x = (i == 4) ? 62 : int'($urandom % H_ACT); // the last square is clipped at the edge.
            y = int'($urandom % V_ACT);
            skip_lines(20);
            set_mouse(x, y);
            wait_frames(1);
        end
        finish_test("cursor_tracking", e0);

        e0 = errors;
        skip_lines(20);
        set_mouse(20, 20);
        press(1'b1, 1'b0, 4);
        skip_lines(5);
        press(1'b0, 1'b1, 4);
        skip_lines(5);
        press(1'b1, 1'b1, 4);
        skip_lines(5);
        press(1'b0, 1'b1, 4);
        wait_frames(1);
        skip_lines(20);
        rst_n       = 1'b0;
        model_state = MENU;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        wait_frames(2);
        finish_test("reset_recovery", e0);

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/vga_pkg.sv
verilog/ui_pkg.sv
verilog/vga_if.sv
verilog/vga_timing.sv
verilog/screen_state_fsm.sv
verilog/draw_background.sv
verilog/draw_cursor.sv
verilog/top_vga.sv
bench/top_vga_assertions.sv
bench/top_vga_tb.sv

// ==== Makefile ====
SIM := obj_dir/Vtop_vga_tb

.PHONY: all run clean

all: run

$(SIM): vlog.f $(wildcard verilog/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module top_vga_tb -f vlog.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir
